// File: cpu_config.svh
// Build-time sizes for the execute/memory slice.
// Data width, data RAM depth and RAM response delay.
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width.
`define XLEN 32

// Data RAM depth in words. The word index wraps modulo this depth.
`define DMEM_WORDS 64

// Cycles from a request to its acknowledge inside the RAM.
`define DMEM_ACK_DELAY 2

`endif

// File: cpu_types_pkg.sv
// Shared types for the execute/memory slice.
// Opcode, ALU-op and requester state enums, and the stage bundles.
`default_nettype none
`include "cpu_config.svh"

package cpu_types_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       regidx_t;

    // RV32I major opcodes. HALT uses the all-ones slot.
    typedef enum logic [6:0] {
        RTYPE  = 7'b0110011,
        ITYPE  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        HALT   = 7'b1111111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE, REQ, WAIT_DROP
    } mem_state_t;

    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        alu_op_t alu_op;
        word_t   pc;
        word_t   rs1_val;
        word_t   rs2_val;
        word_t   imm;
        regidx_t rd;
        logic    reg_wr;
    } ex_in_t;

    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        regidx_t rd;
        logic    reg_wr;
        word_t   alu_res;       // Also the data address.
        word_t   store_data;
        word_t   npc;           // Link value for JAL.
        logic    branch_taken;
        word_t   branch_target;
        logic    dREN;
        logic    dWEN;
        logic    halt;
    } exmem_t;

    typedef struct packed {
        logic    valid;
        regidx_t rd;
        word_t   data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// File: execute_stage.sv
// Execute stage.
// ALU, branch compare, target and link computation, memory strobes.
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import cpu_types_pkg::*;
(
    input  ex_in_t ex_i,
    output exmem_t exmem_o
);

    word_t   op_b;
    word_t   alu_res;
    alu_op_t op;
    logic    is_mem;
    logic    writes_rd;

    always_comb begin
        is_mem    = (ex_i.opcode == LOAD) || (ex_i.opcode == STORE);
        op_b      = (is_mem || ex_i.opcode == ITYPE) ? ex_i.imm : ex_i.rs2_val;
        op        = is_mem ? ADD : ex_i.alu_op; // Address is base plus offset.
        writes_rd = (ex_i.opcode == RTYPE) || (ex_i.opcode == ITYPE) ||
                    (ex_i.opcode == LOAD)  || (ex_i.opcode == JAL);
    end

    always_comb begin
        case (op)
            ADD:     alu_res = ex_i.rs1_val + op_b;
            SUB:     alu_res = ex_i.rs1_val - op_b;
            AND:     alu_res = ex_i.rs1_val & op_b;
            OR:      alu_res = ex_i.rs1_val | op_b;
            XOR:     alu_res = ex_i.rs1_val ^ op_b;
            SLT:     alu_res = word_t'($signed(ex_i.rs1_val) < $signed(op_b));
            SLL:     alu_res = ex_i.rs1_val << op_b[4:0];
            SRL:     alu_res = ex_i.rs1_val >> op_b[4:0];
            default: alu_res = '0;
        endcase
    end

    // Control bits are gated by valid so a bubble carries no side effects.
    always_comb begin
        exmem_o.valid         = ex_i.valid;
        exmem_o.opcode        = ex_i.valid ? ex_i.opcode : RTYPE;
        exmem_o.rd            = ex_i.rd;
        exmem_o.reg_wr        = ex_i.valid && ex_i.reg_wr && writes_rd;
        exmem_o.alu_res       = alu_res;
        exmem_o.store_data    = ex_i.rs2_val;
        exmem_o.npc           = ex_i.pc + word_t'(4);
        exmem_o.branch_taken  = ex_i.valid &&
                                (((ex_i.opcode == BRANCH) && (ex_i.rs1_val == ex_i.rs2_val)) ||
                                 (ex_i.opcode == JAL));
        exmem_o.branch_target = ex_i.pc + ex_i.imm;
        exmem_o.dREN          = ex_i.valid && (ex_i.opcode == LOAD);
        exmem_o.dWEN          = ex_i.valid && (ex_i.opcode == STORE);
        exmem_o.halt          = ex_i.valid && (ex_i.opcode == HALT);
    end

endmodule

`default_nettype wire

// File: ex_mem_latch.sv
// Execute/memory pipeline register.
// Flush, data-hit strobe clear, enable load and hold, in that priority.
`timescale 1ns/10ps
`default_nettype none

module ex_mem_latch
    import cpu_types_pkg::*;
(
    input  logic   CLK,
    input  logic   nRST,
    input  logic   en_i,
    input  logic   flush_i,
    input  logic   dhit_i,
    input  exmem_t exmem_i,
    output exmem_t exmem_o
);

    exmem_t bubble;
    exmem_t next_exmem;

    always_comb begin
        bubble        = '0;
        bubble.opcode = RTYPE;
    end

    always_comb begin
        next_exmem = exmem_o;  // Hold by default.
        if (flush_i && en_i) begin
            next_exmem = bubble;
        end else if (dhit_i) begin
            // Access done. Keep it from being reissued while stalled.
            next_exmem.dREN = 1'b0;
            next_exmem.dWEN = 1'b0;
        end else if (en_i) begin
            next_exmem = exmem_i;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            exmem_o <= bubble;
        end else begin
            exmem_o <= next_exmem;
        end
    end

endmodule

`default_nettype wire

// File: mem_stage.sv
// Memory stage.
// Four-phase requester toward the data RAM, stall signal,
// writeback and redirect records, sticky halt.
`timescale 1ns/10ps
`default_nettype none

module mem_stage
    import cpu_types_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  exmem_t    exmem_i,
    output logic      en_o,
    output logic      dhit_o,
    output logic      dmem_req_o,
    output logic      dmem_wen_o,
    output word_t     dmem_addr_o,
    output word_t     dmem_wdata_o,
    input  logic      dmem_ack_i,
    input  word_t     dmem_rdata_i,
    output wb_t       wb_o,
    output redirect_t redirect_o,
    output logic      halt_o
);

    mem_state_t state;
    mem_state_t next_state;
    logic       pending;
    logic       halt_q;

    assign pending = exmem_i.dREN || exmem_i.dWEN;
    assign en_o    = !pending;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (pending && !dmem_ack_i) next_state = REQ;
            REQ:       if (dmem_ack_i) next_state = WAIT_DROP;
            WAIT_DROP: if (!dmem_ack_i) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            halt_q <= 1'b0;
        end else begin
            state  <= next_state;
            halt_q <= halt_o;
        end
    end

    // Address and data come straight from the latch, which holds during the access.
    assign dmem_req_o   = (state == REQ);
    assign dmem_wen_o   = exmem_i.dWEN;
    assign dmem_addr_o  = exmem_i.alu_res;
    assign dmem_wdata_o = exmem_i.store_data;
    assign dhit_o       = (state == REQ) && dmem_ack_i;

    always_comb begin
        wb_o.rd = exmem_i.rd;
        case (exmem_i.opcode)
            LOAD:    wb_o.data = dmem_rdata_i;
            JAL:     wb_o.data = exmem_i.npc;
            default: wb_o.data = exmem_i.alu_res;
        endcase
        wb_o.valid = exmem_i.valid && exmem_i.reg_wr && (exmem_i.rd != '0);
        if (exmem_i.opcode == LOAD)
            wb_o.valid = wb_o.valid && dhit_o;  // Load data exists only in the hit cycle.
    end

    assign redirect_o.valid  = exmem_i.valid && exmem_i.branch_taken;
    assign redirect_o.target = exmem_i.branch_target;

    assign halt_o = halt_q || (exmem_i.valid && exmem_i.halt);

endmodule

`default_nettype wire

// File: data_ram.sv
// Word-addressed data RAM.
// Answers the four-phase handshake after a fixed delay.
`timescale 1ns/10ps
`default_nettype none
`include "cpu_config.svh"

module data_ram (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             req_i,
    input  logic             wen_i,
    input  logic [`XLEN-1:0] addr_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic             ack_o,
    output logic [`XLEN-1:0] rdata_o
);

    localparam int AW = $clog2(`DMEM_WORDS);
    localparam int CW = $clog2(`DMEM_ACK_DELAY) + 1;

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    idx;
    logic [CW-1:0]    cnt;
    logic             fire;

    assign idx  = addr_i[AW+1:2];   // Byte address to word index.
    assign fire = req_i && !ack_o && (cnt == CW'(`DMEM_ACK_DELAY - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt   <= '0;
            ack_o <= 1'b0;
        end else if (ack_o) begin
            if (!req_i)
                ack_o <= 1'b0;      // Requester dropped req.
        end else if (fire) begin
            cnt   <= '0;
            ack_o <= 1'b1;
        end else if (req_i) begin
            cnt <= cnt + CW'(1);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (fire && wen_i) begin
            mem[idx] <= wdata_i;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire && !wen_i)
            rdata_o <= mem[idx];    // Valid together with ack.
    end

endmodule

`default_nettype wire

// File: ex_mem_top.sv
// Top level of the execute/memory slice.
// Execute stage, pipeline latch, memory stage and data RAM.
`timescale 1ns/10ps
`default_nettype none

module ex_mem_top
    import cpu_types_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  ex_in_t    ex_i,
    input  logic      flush_i,
    output logic      ready_o,
    output wb_t       wb_o,
    output redirect_t redirect_o,
    output logic      halt_o
);

    exmem_t ex_out;
    exmem_t latch_out;
    logic   dhit;
    logic   dmem_req;
    logic   dmem_wen;
    logic   dmem_ack;
    word_t  dmem_addr;
    word_t  dmem_wdata;
    word_t  dmem_rdata;

    execute_stage u_execute (
        .ex_i    (ex_i),
        .exmem_o (ex_out)
    );

    // The stall signal doubles as the latch enable.
    ex_mem_latch u_latch (
        .CLK     (CLK),
        .nRST    (nRST),
        .en_i    (ready_o),
        .flush_i (flush_i),
        .dhit_i  (dhit),
        .exmem_i (ex_out),
        .exmem_o (latch_out)
    );

    mem_stage u_mem (
        .CLK          (CLK),
        .nRST         (nRST),
        .exmem_i      (latch_out),
        .en_o         (ready_o),
        .dhit_o       (dhit),
        .dmem_req_o   (dmem_req),
        .dmem_wen_o   (dmem_wen),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_ack_i   (dmem_ack),
        .dmem_rdata_i (dmem_rdata),
        .wb_o         (wb_o),
        .redirect_o   (redirect_o),
        .halt_o       (halt_o)
    );

    data_ram u_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .req_i   (dmem_req),
        .wen_i   (dmem_wen),
        .addr_i  (dmem_addr),
        .wdata_i (dmem_wdata),
        .ack_o   (dmem_ack),
        .rdata_o (dmem_rdata)
    );

endmodule

`default_nettype wire

// File: ex_mem_props.sv
// Concurrent checks on the data RAM handshake and the latch strobes.
// Bound into the memory stage, whose exmem_i is the latch output.
`timescale 1ns/10ps
`default_nettype none

module ex_mem_props (
    input logic CLK,
    input logic nRST,
    input logic req_i,
    input logic ack_i,
    input logic dren_i,
    input logic dwen_i
);

    // A new request waits until the previous acknowledge has dropped.
    req_after_ack: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(req_i) |-> !ack_i)
        else $error("dmem_req raised while dmem_ack was high");

    ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ack_i) |-> req_i)
        else $error("dmem_ack rose without dmem_req");

    reset_clears_strobes: assert property (@(posedge CLK)
        $rose(nRST) |-> !dren_i && !dwen_i)
        else $error("latch dREN or dWEN set right after reset");

endmodule

bind mem_stage ex_mem_props u_props (
    .CLK    (CLK),
    .nRST   (nRST),
    .req_i  (dmem_req_o),
    .ack_i  (dmem_ack_i),
    .dren_i (exmem_i.dREN),
    .dwen_i (exmem_i.dWEN)
);

`default_nettype wire

// File: tb_ex_mem.sv
// Testbench for the execute/memory slice.
// Stimulus table with model-derived results, LFSR operands, output monitor.
`timescale 1ns/10ps
`default_nettype none
`include "cpu_config.svh"

module tb_ex_mem
    import cpu_types_pkg::*;
();

    typedef struct packed {
        ex_in_t  in;
        logic    flush;
        logic    wb_valid;
        regidx_t wb_rd;
        word_t   wb_data;
        logic    redir_valid;
        word_t   redir_target;
    } row_t;

    logic      CLK;
    logic      nRST;
    ex_in_t    ex_i;
    logic      flush_i;
    logic      ready_o;
    wb_t       wb_o;
    redirect_t redirect_o;
    logic      halt_o;

    row_t        rows[$];
    wb_t         exp_wb[$];
    word_t       exp_target[$];
    word_t       model_mem[int];    // Words never written read as zero.
    logic [15:0] lfsr = 16'd45498;
    logic        halt_issued = 1'b0;
    logic        timed_out = 1'b0;
    int          n_checks = 0;
    int          n_errors = 0;

    ex_mem_top dut_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .ex_i       (ex_i),
        .flush_i    (flush_i),
        .ready_o    (ready_o),
        .wb_o       (wb_o),
        .redirect_o (redirect_o),
        .halt_o     (halt_o)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < `XLEN; i++)
            w = {w[`XLEN-2:0], lfsr_bit()};
        return w;
    endfunction

    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    // Adds one issued bundle and its expected results; the model RAM follows program order.
    task automatic add_row(input opcode_t opc, input alu_op_t aop, input word_t pc,
                           input word_t a, input word_t b, input word_t imm,
                           input regidx_t rd, input logic fl);
        row_t r;
        int   key;
        r = '0;
        r.in.valid = 1'b1;
        r.in.opcode = opc;
        r.in.alu_op = aop;
        r.in.pc = pc;
        r.in.rs1_val = a;
        r.in.rs2_val = b;
        r.in.imm = imm;
        r.in.rd = rd;
        r.in.reg_wr = 1'b1;
        r.flush = fl;
        r.wb_rd = rd;
        r.redir_target = pc + imm;
        key = int'(((a + imm) >> 2) % `DMEM_WORDS);
        if (!fl) begin
            case (opc)
                RTYPE, ITYPE: begin
                    r.wb_valid = (rd != 5'd0);
                    r.wb_data  = alu_model(aop, a, (opc == ITYPE) ? imm : b);
                end
                LOAD: begin
                    r.wb_valid = (rd != 5'd0);
                    r.wb_data  = model_mem.exists(key) ? model_mem[key] : '0;
                end
                STORE:   model_mem[key] = b;
                BRANCH:  r.redir_valid = (a == b);
                JAL: begin
                    r.redir_valid = 1'b1;
                    r.wb_valid    = (rd != 5'd0);
                    r.wb_data     = pc + 32'd4;
                end
                default: ;
            endcase
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        alu_op_t op;
        regidx_t rd;
        op = op.first();
        rd = 5'd1;
        repeat (8) begin
            add_row(RTYPE, op, 32'h0, rand_word(), rand_word(), 32'h0, rd, 1'b0);
            op = op.next();
            rd = rd + 5'd1;
        end
        add_row(ITYPE, ADD, 32'h0, rand_word(), 32'h0, rand_word(), 5'd9, 1'b0);
        add_row(ITYPE, XOR, 32'h0, rand_word(), 32'h0, rand_word(), 5'd0, 1'b0);
        add_row(LOAD, ADD, 32'h0, 32'h30, 32'h0, 32'h10, 5'd11, 1'b0);   // Never written.
        add_row(STORE, ADD, 32'h0, 32'h100, rand_word(), 32'h8, 5'd0, 1'b0); // Wraps to word 2.
        add_row(LOAD, ADD, 32'h0, 32'h8, 32'h0, 32'h0, 5'd12, 1'b0);
        add_row(RTYPE, SUB, 32'h0, rand_word(), rand_word(), 32'h0, 5'd13, 1'b0);
        add_row(STORE, ADD, 32'h0, 32'h40, rand_word(), 32'h4, 5'd0, 1'b0);
        add_row(LOAD, ADD, 32'h0, 32'h44, 32'h0, 32'h0, 5'd14, 1'b0);
        add_row(BRANCH, ADD, 32'h200, 32'h5, 32'h5, 32'h40, 5'd0, 1'b0);
        add_row(BRANCH, ADD, 32'h204, 32'h5, 32'h6, 32'h40, 5'd0, 1'b0);
        add_row(JAL, ADD, 32'h300, 32'h0, 32'h0, 32'hFFFF_FFF0, 5'd1, 1'b0);
        // Flushed entries leave no trace.
        add_row(STORE, ADD, 32'h0, 32'h8, rand_word(), 32'h0, 5'd0, 1'b1);
        add_row(LOAD, ADD, 32'h0, 32'h8, 32'h0, 32'h0, 5'd15, 1'b0);
        add_row(RTYPE, OR, 32'h0, rand_word(), rand_word(), 32'h0, 5'd16, 1'b1);
        add_row(JAL, ADD, 32'h400, 32'h0, 32'h0, 32'h20, 5'd2, 1'b1);
        add_row(LOAD, ADD, 32'h0, 32'h8, 32'h0, 32'h0, 5'd17, 1'b1);
        add_row(ITYPE, ADD, 32'h0, 32'h1, 32'h0, 32'h2, 5'd18, 1'b0);
        add_row(HALT, ADD, 32'h0, 32'h0, 32'h0, 32'h0, 5'd0, 1'b0);
    endtask

    // Returns in a cycle where ready_o is high, so the next edge accepts ex_i.
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge CLK);
        while (!ready_o && !timed_out) begin
            n++;
            if (n > 50) begin
                n_errors++;
                timed_out = 1'b1;
                $display("Timed out waiting for ready_o at %0t", $time);
            end else begin
                @(negedge CLK);
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge CLK);
        while ((exp_wb.size() != 0 || exp_target.size() != 0 || !ready_o) && !timed_out) begin
            n++;
            if (n > 100) begin
                n_errors++;
                timed_out = 1'b1;
                $display("Expected writebacks or redirects never arrived by %0t", $time);
            end else begin
                @(negedge CLK);
            end
        end
    endtask

    task automatic expect_row(input row_t r);
        wb_t e;
        e.valid = 1'b1;
        e.rd    = r.wb_rd;
        e.data  = r.wb_data;
        if (r.wb_valid)
            exp_wb.push_back(e);
        if (r.redir_valid)
            exp_target.push_back(r.redir_target);
        if (r.in.opcode == HALT && !r.flush)
            halt_issued = 1'b1;
    endtask

    always @(negedge CLK) begin : monitor
        wb_t   e;
        word_t t;
        if (nRST) begin
            if (halt_o && !halt_issued) begin
                n_errors++;
                $display("ERR %0t: halt_o high before any HALT was issued", $time);
            end
            if (wb_o.valid) begin
                if (exp_wb.size() == 0) begin
                    n_errors++;
                    $display("Unexpected writeback to x%0d at %0t", wb_o.rd, $time);
                end else begin
                    e = exp_wb.pop_front();
                    n_checks++;
                    if (wb_o.rd != e.rd || wb_o.data != e.data) begin
                        n_errors++;
                        $display("ERR %0t: writeback x%0d = %h, expected x%0d = %h",
                                 $time, wb_o.rd, wb_o.data, e.rd, e.data);
                    end
                end
            end
            if (redirect_o.valid) begin
                if (exp_target.size() == 0) begin
                    n_errors++;
                    $display("Unexpected redirect to %h at %0t", redirect_o.target, $time);
                end else begin
                    t = exp_target.pop_front();
                    n_checks++;
                    if (redirect_o.target != t) begin
                        n_errors++;
                        $display("ERR %0t: redirect to %h, expected %h",
                                 $time, redirect_o.target, t);
                    end
                end
            end
        end
    end

    initial begin
        nRST    = 1'b0;
        ex_i    = '0;
        flush_i = 1'b0;
        build_table();
        repeat (5) @(negedge CLK);
        n_checks++;
        if (!ready_o || wb_o.valid || redirect_o.valid || halt_o) begin
            n_errors++;
            $display("ERR %0t: outputs not at their reset values", $time);
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        foreach (rows[i]) begin
            if (!timed_out) begin
                ex_i    <= rows[i].in;     // Held until accepted.
                flush_i <= rows[i].flush;
                wait_ready();
                if (!timed_out) begin
                    expect_row(rows[i]);
                    @(posedge CLK);
                end
            end
        end
        if (!timed_out) begin
            ex_i    <= '0;
            flush_i <= 1'b0;
            wait_drain();
        end
        if (!timed_out) begin
            repeat (5) begin
                @(negedge CLK);
                n_checks++;
                if (!halt_o) begin
                    n_errors++;
                    $display("ERR %0t: halt_o low after HALT", $time);
                end
            end
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
cpu_types_pkg.sv
execute_stage.sv
ex_mem_latch.sv
mem_stage.sv
data_ram.sv
ex_mem_top.sv
ex_mem_props.sv
tb_ex_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute/memory slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_ex_mem \
    -f filelist.f -o tb_ex_mem > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ex_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
